// File: fpPkg.sv
// Single-precision float package with field widths, word and class types, and constants
`default_nettype none

package fpPkg;

    localparam int expWidth = 8;
    localparam int manWidth = 23;

    // Extra low bits kept below the mantissa while aligning
    localparam int guardWidth = 8;
    localparam int alignedWidth = 1 + manWidth + guardWidth;

    localparam int expBias = 127;
    localparam int expMax = 255;

    typedef logic [expWidth-1:0] fpExp;
    typedef logic [alignedWidth-1:0] alignedMan;

    typedef struct packed {
        logic                sign;
        fpExp                exponent;
        logic [manWidth-1:0] mantissa;
    } fpWord;

    // One set of flags per operand
    typedef struct packed {
        logic isNaN;
        logic isInf;
        logic isZero;
        logic isSub;
        logic sign;
    } fpClass;

    localparam fpWord quietNaN = 32'h7FC0_0000;

endpackage

`default_nettype wire

// File: fpBus.sv
// Bus between the classify, alignment and mantissa add stages of the float adder
`default_nettype none
`timescale 1ns/1ps

interface fpBus
    import fpPkg::*;
(
    input logic clk
);

    // Unpacked operands, B already carries its effective sign
    fpExp                exponentA;
    fpExp                exponentB;
    logic [manWidth-1:0] mantissaA;
    logic [manWidth-1:0] mantissaB;
    fpClass              classA;
    fpClass              classB;
    logic                effSub;

    // Alignment results
    logic                aLarger;
    logic                bLarger;
    fpExp                exponentOut;
    alignedMan           alignedMantissaA;
    alignedMan           alignedMantissaB;
    logic                sticky;
    logic                shiftOverflow;

    modport classify (
        output exponentA, exponentB, mantissaA, mantissaB,
               classA, classB, effSub
    );

    modport align (
        input  clk, exponentA, exponentB, mantissaA, mantissaB, classA, classB,
        output aLarger, bLarger, exponentOut, alignedMantissaA, alignedMantissaB,
               sticky, shiftOverflow
    );

    modport add (
        input aLarger, bLarger, exponentOut, alignedMantissaA, alignedMantissaB,
              sticky, shiftOverflow, effSub, classA, classB
    );

endinterface

`default_nettype wire

// File: fpClassify.sv
// Operand unpacking, class flags and the special-case result for NaN, infinity and zero
`default_nettype none
`timescale 1ns/1ps

module fpClassify
    import fpPkg::*;
(
    input  fpWord opA,
    input  fpWord opB,
    input  logic  sub,
    fpBus.classify bus,
    output fpWord specialResult,
    output logic  useSpecial
);

    fpWord  opBNeg;
    fpClass classA;
    fpClass classB;

    function automatic fpClass classOf(fpWord w);
        fpClass c;
        logic   expOnes;
        logic   manZero;
        expOnes  = (w.exponent == fpExp'(expMax));
        manZero  = (w.mantissa == '0);
        c.isNaN  = expOnes & ~manZero;
        c.isInf  = expOnes & manZero;
        c.isZero = (w.exponent == '0) & manZero;
        c.isSub  = (w.exponent == '0) & ~manZero;
        c.sign   = w.sign;
        return c;
    endfunction

    // Subtraction is addition of B with its sign flipped
    assign opBNeg = '{sign: opB.sign ^ sub, exponent: opB.exponent, mantissa: opB.mantissa};

    assign classA = classOf(opA);
    assign classB = classOf(opBNeg);

    assign bus.exponentA = opA.exponent;
    assign bus.exponentB = opBNeg.exponent;
    assign bus.mantissaA = opA.mantissa;
    assign bus.mantissaB = opBNeg.mantissa;
    assign bus.classA    = classA;
    assign bus.classB    = classB;
    assign bus.effSub    = classA.sign ^ classB.sign;

    assign useSpecial = classA.isNaN | classB.isNaN | classA.isInf | classB.isInf |
                        classA.isZero | classB.isZero;

    always_comb
    begin
        if (classA.isNaN | classB.isNaN)
            specialResult = quietNaN;
        else if (classA.isInf & classB.isInf)
            specialResult = (classA.sign == classB.sign) ? opA : quietNaN;
        else if (classA.isInf)
            specialResult = opA;
        else if (classB.isInf)
            specialResult = opBNeg;
        else if (classA.isZero & classB.isZero)
            // Only two negative zeros keep the minus sign
            specialResult = '{sign: classA.sign & classB.sign, exponent: '0, mantissa: '0};
        else if (classA.isZero)
            specialResult = opBNeg;
        else
            specialResult = opA;
    end

endmodule

`default_nettype wire

// File: alignment.sv
// Exponent compare and mantissa alignment with sticky collection for the float adder
`default_nettype none
`timescale 1ns/1ps

module alignment
    import fpPkg::*;
(
    fpBus.align bus
);

    fpExp      effExpA;
    fpExp      effExpB;
    fpExp      expDiff;
    alignedMan fullA;
    alignedMan fullB;
    alignedMan smallerFull;
    alignedMan shiftedSmaller;
    alignedMan lostBits;
    logic      shiftedOut;

    // Subnormals sit at the minimum exponent and have no hidden bit
    assign effExpA = bus.classA.isSub ? fpExp'(1) : bus.exponentA;
    assign effExpB = bus.classB.isSub ? fpExp'(1) : bus.exponentB;

    assign fullA = {~(bus.classA.isSub | bus.classA.isZero), bus.mantissaA,
                    {guardWidth{1'b0}}};
    assign fullB = {~(bus.classB.isSub | bus.classB.isZero), bus.mantissaB,
                    {guardWidth{1'b0}}};

    assign bus.aLarger = (effExpA > effExpB);
    assign bus.bLarger = (effExpB > effExpA);

    always_comb
    begin
        if (bus.bLarger)
        begin
            bus.exponentOut = effExpB;
            expDiff         = effExpB - effExpA;
            smallerFull     = fullA;
        end
        else
        begin
            // Equal exponents land here too, with a shift of zero
            bus.exponentOut = effExpA;
            expDiff         = effExpA - effExpB;
            smallerFull     = fullB;
        end
    end

    assign shiftedSmaller = smallerFull >> expDiff;

    // Bits that drop off the end of the guard field
    assign lostBits = smallerFull & ~({alignedWidth{1'b1}} << expDiff);

    assign shiftedOut = (expDiff >= fpExp'(alignedWidth));

    assign bus.sticky = ~shiftedOut & (|lostBits);

    // Whole operand gone below the field, which matters most for long subtractions
    assign bus.shiftOverflow = shiftedOut & (|smallerFull);

    // The larger operand passes through unshifted
    assign bus.alignedMantissaA = bus.bLarger ? shiftedSmaller : fullA;
    assign bus.alignedMantissaB = bus.bLarger ? fullB : shiftedSmaller;

    // A subnormal can still win the compare against a zero, so only normal winners count
    largerIsNormal: assert property (@(posedge bus.clk)
        ((bus.aLarger & ~bus.classA.isSub) | (bus.bLarger & ~bus.classB.isSub)) |->
            (bus.aLarger ? bus.alignedMantissaA[alignedWidth-1]
                         : bus.alignedMantissaB[alignedWidth-1]));

endmodule

`default_nettype wire

// File: mantissaAddNormalize.sv
// Aligned mantissa add or subtract with normalization, nearest-even rounding and packing
`default_nettype none
`timescale 1ns/1ps

module mantissaAddNormalize
    import fpPkg::*;
(
    fpBus.add bus,
    output fpWord normalResult
);

    typedef logic signed [expWidth+1:0] wideExp;

    logic                    aIsBig;
    logic                    resultSign;
    logic                    lowBit;
    alignedMan               bigMan;
    alignedMan               smallMan;
    logic [alignedWidth+1:0] sum;
    logic [alignedWidth+1:0] norm;
    logic [5:0]              lzCount;
    logic                    roundUp;
    logic [manWidth+1:0]     rounded;
    logic [manWidth-1:0]     manOut;
    wideExp                  expNorm;
    wideExp                  expFinal;

    function automatic logic [5:0] leadingZeros(logic [alignedWidth+1:0] value);
        logic [5:0] count;
        count = 6'(alignedWidth + 2);
        for (int i = 0; i < alignedWidth + 2; i++)
        begin
            if (value[i])
                count = 6'(alignedWidth + 1 - i);
        end
        return count;
    endfunction

    // With equal exponents the mantissas decide which magnitude is larger
    assign aIsBig = bus.aLarger |
                    (~bus.bLarger & (bus.alignedMantissaA >= bus.alignedMantissaB));

    assign bigMan     = aIsBig ? bus.alignedMantissaA : bus.alignedMantissaB;
    assign smallMan   = aIsBig ? bus.alignedMantissaB : bus.alignedMantissaA;
    assign resultSign = aIsBig ? bus.classA.sign : bus.classB.sign;
    assign lowBit     = bus.sticky | bus.shiftOverflow;

    // Carry on top, sticky as a half bit below the field so a borrow lands correctly
    always_comb
    begin
        if (bus.effSub)
            sum = {1'b0, bigMan, 1'b0} - {1'b0, smallMan, lowBit};
        else
            sum = {1'b0, bigMan, 1'b0} + {1'b0, smallMan, lowBit};
    end

    // Leading one moves to the carry position, a carry needs no shift at all
    assign lzCount = leadingZeros(sum);
    assign norm    = sum << lzCount;
    assign expNorm = wideExp'({2'b00, bus.exponentOut}) + wideExp'(1)
                   - wideExp'({4'b0000, lzCount});

    // Guard sits right below the stored mantissa, everything beneath it is sticky
    assign roundUp = norm[alignedWidth-manWidth] &
                     (norm[alignedWidth-manWidth+1] | (|norm[alignedWidth-manWidth-1:0]));

    assign rounded = {1'b0, norm[alignedWidth+1:alignedWidth-manWidth+1]}
                   + {{(manWidth+1){1'b0}}, roundUp};

    // Rounding up an all-ones mantissa carries into the exponent
    assign manOut   = rounded[manWidth+1] ? rounded[manWidth:1] : rounded[manWidth-1:0];
    assign expFinal = expNorm + wideExp'({{(expWidth+1){1'b0}}, rounded[manWidth+1]});

    always_comb
    begin
        if (sum == '0)
            normalResult = '0;
        else if (expFinal < wideExp'(1))
            normalResult = '{sign: resultSign, exponent: '0, mantissa: '0};
        else if (expFinal >= wideExp'(expMax))
            normalResult = '{sign: resultSign, exponent: fpExp'(expMax), mantissa: '0};
        else
            normalResult = '{sign: resultSign, exponent: fpExp'(expFinal), mantissa: manOut};
    end

endmodule

`default_nettype wire

// File: resultMerge.sv
// Result select and register with the four-phase req/ack handshake
`default_nettype none
`timescale 1ns/1ps

module resultMerge
    import fpPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  req,
    input  fpWord specialResult,
    input  fpWord normalResult,
    input  logic  useSpecial,
    output fpWord result,
    output logic  ack
);

    logic  accept;
    fpWord selected;

    // A new operation starts only once the previous ack has gone low
    assign accept   = req & ~ack;
    assign selected = useSpecial ? specialResult : normalResult;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            ack <= 1'b0;
        else if (accept)
            ack <= 1'b1;
        else if (!req)
            ack <= 1'b0;
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            result <= '0;
        else if (accept)
            result <= selected;
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req));

    // The environment may sample result any time while ack stays up
    resultHeld: assert property (@(posedge clk) disable iff (!rstN)
        (ack && $past(ack)) |-> $stable(result));

endmodule

`default_nettype wire

// File: fpAdder.sv
// Single-precision float adder and subtractor top level behind a req/ack handshake
`default_nettype none
`timescale 1ns/1ps

module fpAdder
    import fpPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  req,
    input  logic  sub,
    input  fpWord opA,
    input  fpWord opB,
    output fpWord result,
    output logic  ack
);

    fpWord specialResult;
    fpWord normalResult;
    logic  useSpecial;

    fpBus bus (.clk(clk));

    fpClassify i_fpClassify (
        .opA           (opA),
        .opB           (opB),
        .sub           (sub),
        .bus           (bus.classify),
        .specialResult (specialResult),
        .useSpecial    (useSpecial)
    );

    alignment i_alignment (
        .bus (bus.align)
    );

    mantissaAddNormalize i_mantissaAddNormalize (
        .bus          (bus.add),
        .normalResult (normalResult)
    );

    resultMerge i_resultMerge (
        .clk           (clk),
        .rstN          (rstN),
        .req           (req),
        .specialResult (specialResult),
        .normalResult  (normalResult),
        .useSpecial    (useSpecial),
        .result        (result),
        .ack           (ack)
    );

endmodule

`default_nettype wire

// File: tbClock.sv
// Free-running testbench clock with a 40 ns period
`default_nettype none
`timescale 1ns/1ps

module tbClock
(
    output logic clk
);

    localparam time halfPeriod = 20ns;

    initial
    begin
        clk = 1'b0;
        forever
            #halfPeriod clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tbFpAdder.sv
// Directed and random tests of the float adder through its req/ack handshake
`default_nettype none
`timescale 1ns/1ps

module tbFpAdder
    import fpPkg::*;
;

    localparam int ackWaitCycles = 10;
    // About 230 transactions of two cycles each, plus room for the per-phase wait bound
    localparam int timeoutCycles = 4000;

    logic        clk;
    logic        rstN;
    logic        req;
    logic        sub;
    fpWord       opA;
    fpWord       opB;
    fpWord       result;
    logic        ack;
    int          errors;
    int          checks;
    int          errorsBefore;
    int          cycles;
    logic [31:0] rngState;

    tbClock i_tbClock (.clk(clk));

    fpAdder i_fpAdder (
        .clk    (clk),
        .rstN   (rstN),
        .req    (req),
        .sub    (sub),
        .opA    (opA),
        .opB    (opB),
        .result (result),
        .ack    (ack)
    );

    function automatic logic [31:0] nextRandom(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Exponents 100 to 154 keep every sum and difference in the normal range
    function automatic fpWord randomOperand(logic [31:0] r);
        return '{sign: r[31], exponent: fpExp'(100 + r[30:23] % 55), mantissa: r[22:0]};
    endfunction

    // Exact widening of a normal float into a double
    function automatic real toReal(fpWord w);
        logic [10:0] e;
        e = {3'b000, w.exponent} + 11'd896;
        return $bitstoreal({w.sign, e, w.mantissa, 29'd0});
    endfunction

    // Double to float with round to nearest, ties to even
    function automatic fpWord toFloat(real r);
        logic [63:0] d;
        logic [24:0] m;
        logic        guard;
        logic        sticky;
        int          e;
        d = $realtobits(r);
        if (r == 0.0)
            return '0;
        e      = int'(d[62:52]) - 896;
        m      = {2'b01, d[51:29]};
        guard  = d[28];
        sticky = |d[27:0];
        if (guard & (m[0] | sticky))
            m = m + 25'd1;
        if (m[24])
        begin
            e = e + 1;
            m = m >> 1;
        end
        return '{sign: d[63], exponent: fpExp'(e), mantissa: m[22:0]};
    endfunction

    function automatic fpWord expectedSum(fpWord a, fpWord b, logic s);
        real sum;
        sum = s ? toReal(a) - toReal(b) : toReal(a) + toReal(b);
        return toFloat(sum);
    endfunction

    task automatic checkWord(string name, fpWord expected, fpWord actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkAck(logic expected);
        checks++;
        if (ack !== expected)
        begin
            errors++;
            $display("mismatch at %0t ns: ack expected %b, got %b", $time, expected, ack);
        end
    endtask

    // Called 2 ns after an edge, returns 2 ns after the edge where ack reached the level
    task automatic waitForAck(logic level, string phase);
        int n;
        n = 0;
        @(posedge clk);
        #2;
        while (ack !== level && n < ackWaitCycles)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        if (ack !== level)
        begin
            errors++;
            $display("handshake stalled at %0t ns: ack never went to %b in the %s phase",
                     $time, level, phase);
        end
    endtask

    task automatic doOperation(fpWord a, fpWord b, logic s, output fpWord got);
        opA = a;
        opB = b;
        sub = s;
        req = 1'b1;
        waitForAck(1'b1, "request");
        got = result;
        req = 1'b0;
        waitForAck(1'b0, "release");
    endtask

    task automatic runCase(fpWord a, fpWord b, logic s, fpWord expected);
        fpWord got;
        doOperation(a, b, s, got);
        checkWord("result", expected, got);
    endtask

    task automatic runModelCase(fpWord a, fpWord b, logic s);
        runCase(a, b, s, expectedSum(a, b, s));
    endtask

    task automatic finishTest(string name);
        $display("%-24s %s", name, (errors == errorsBefore) ? "ok" : "has errors");
        errorsBefore = errors;
    endtask

    task automatic testHandshake();
        checkAck(1'b0);
        checkWord("result", '0, result);
        opA = 32'h3F80_0000;
        opB = 32'h3F80_0000;
        sub = 1'b0;
        req = 1'b1;
        @(posedge clk);
        #2;
        checkAck(1'b1);
        // A held request keeps ack up and must not capture the changed operand
        opA = 32'h4000_0000;
        repeat (3)
        begin
            @(posedge clk);
            #2;
            checkAck(1'b1);
        end
        checkWord("result", 32'h4000_0000, result);
        req = 1'b0;
        @(posedge clk);
        #2;
        checkAck(1'b0);
        finishTest("reset and handshake");
    endtask

    task automatic testNearExponents();
        runModelCase(32'h3F80_0000, 32'h3F80_0000, 1'b0);
        runModelCase(32'h3FC0_0000, 32'h4010_0000, 1'b0);
        runModelCase(32'h4040_0000, 32'h3F80_0000, 1'b1);
        runModelCase(32'hC0A0_0000, 32'h4049_0FDB, 1'b0);
        finishTest("near exponents");
    endtask

    task automatic testRounding();
        // Ties with even and odd last bits, then a sticky-only case
        runModelCase(32'h3F80_0000, 32'h3380_0000, 1'b0);
        runModelCase(32'h3F80_0001, 32'h3380_0000, 1'b0);
        runModelCase(32'h3F80_0000, 32'h3380_0001, 1'b0);
        runModelCase(32'h3F80_0000, 32'h3380_0001, 1'b1);
        runModelCase(32'h3F80_0000, 32'h2180_0000, 1'b0);
        runModelCase(32'h3F80_0000, 32'h2180_0000, 1'b1);
        finishTest("rounding");
    endtask

    task automatic testCancellation();
        runCase(32'h4049_0FDB, 32'h4049_0FDB, 1'b1, 32'h0000_0000);
        runCase(32'hC049_0FDB, 32'h4049_0FDB, 1'b0, 32'h0000_0000);
        runModelCase(32'h3F80_0001, 32'h3F80_0000, 1'b1);
        runModelCase(32'h3F80_0000, 32'h3F7F_FFFF, 1'b1);
        runModelCase(32'h4B00_0001, 32'hCB00_0000, 1'b0);
        finishTest("cancellation");
    endtask

    task automatic testSpecial();
        runCase(32'h7F80_0001, 32'h3F80_0000, 1'b0, quietNaN);
        runCase(32'h3F80_0000, 32'hFFC0_0000, 1'b0, quietNaN);
        runCase(32'h7F80_0000, 32'hFF80_0000, 1'b0, quietNaN);
        runCase(32'h7F80_0000, 32'h7F80_0000, 1'b1, quietNaN);
        runCase(32'h7F80_0000, 32'h3F80_0000, 1'b0, 32'h7F80_0000);
        runCase(32'h3F80_0000, 32'h7F80_0000, 1'b1, 32'hFF80_0000);
        runCase(32'h0000_0000, 32'h4049_0FDB, 1'b0, 32'h4049_0FDB);
        runCase(32'h0000_0000, 32'h4049_0FDB, 1'b1, 32'hC049_0FDB);
        runCase(32'h8000_0000, 32'h8000_0000, 1'b0, 32'h8000_0000);
        runCase(32'h0000_0000, 32'h8000_0000, 1'b0, 32'h0000_0000);
        runCase(32'h8000_0000, 32'h0000_0000, 1'b1, 32'h8000_0000);
        finishTest("special cases");
    endtask

    task automatic testRandom();
        fpWord a;
        fpWord b;
        logic  s;
        for (int i = 0; i < 200; i++)
        begin
            rngState = nextRandom(rngState);
            a        = randomOperand(rngState);
            rngState = nextRandom(rngState);
            b        = randomOperand(rngState);
            rngState = nextRandom(rngState);
            s        = rngState[0];
            runModelCase(a, b, s);
        end
        finishTest("random regression");
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= timeoutCycles)
        begin
            $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial
    begin
        rstN         = 1'b0;
        req          = 1'b0;
        sub          = 1'b0;
        opA          = '0;
        opB          = '0;
        errors       = 0;
        checks       = 0;
        errorsBefore = 0;
        cycles       = 0;
        rngState     = 32'h6057f4aa;
        repeat (16) @(posedge clk);
        #2;
        rstN = 1'b1;
        @(posedge clk);
        #2;
        testHandshake();
        testNearExponents();
        testRounding();
        testCancellation();
        testSpecial();
        testRandom();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
fpPkg.sv
fpBus.sv
fpClassify.sv
alignment.sv
mantissaAddNormalize.sv
resultMerge.sv
fpAdder.sv
tbClock.sv
tbFpAdder.sv

// File: Makefile
SOURCES := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/VtbFpAdder
	./obj_dir/VtbFpAdder > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi

obj_dir/VtbFpAdder: sim.f $(SOURCES)
	verilator --binary --assert -f sim.f --top-module tbFpAdder -o VtbFpAdder

clean:
	rm -rf obj_dir sim.log
